// File: z180_io_pkg.sv
`default_nettype none

package z180_io_pkg;

    // **************************************************
    // Bus widths
    // **************************************************

    // The Z8S180 I/O cycle drives an 8 bit port address onto the bus
    localparam int ADDR_W = 8;
    localparam int DATA_W = 8;

    // Two low address bits pick one of the four ports in the block
    localparam int PORT_SEL_W = 2;

    // First address of the port block with the select bits at zero
    localparam logic [ADDR_W-1:0] PORT_BASE = 8'h40;

    // **************************************************
    // Write queue
    // **************************************************

    // Depth must stay a power of two so the pointers wrap by themselves
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;

    // **************************************************
    // State encodings
    // **************************************************

    // The iorq write FSM opens one tick per bus write and then parks in hold
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_TICK,
        WR_HOLD
    } wr_state_t;

    // The drain FSM walks each entry through the four-phase handshake
    typedef enum logic [1:0] {
        DR_IDLE,
        DR_LOAD,
        DR_REQ,
        DR_RELEASE
    } drain_state_t;

endpackage

`default_nettype wire

// File: iorq_wr_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// Recognizes an I/O write bus cycle and produces one tick per cycle
// The bus inputs are expected to meet setup and hold at the rising edge of phi
// No synchronizer is placed in front of iorq or wr
module iorq_wr_fsm (
    input  wire  phi,
    input  wire  reset,
    input  wire  iorq,
    input  wire  wr,
    output logic wr_tick
);

    z180_io_pkg::wr_state_t state_reg;
    z180_io_pkg::wr_state_t state_next;

    // State register with synchronous reset
    always_ff @(posedge phi) begin
        if (reset) begin
            state_reg <= z180_io_pkg::WR_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    // Any edge that samples iorq or wr low sends the FSM back to idle
    always_comb begin
        state_next = z180_io_pkg::WR_IDLE;
        case (state_reg)
            z180_io_pkg::WR_IDLE: begin
                if (iorq && wr) begin
                    state_next = z180_io_pkg::WR_TICK;
                end
            end
            z180_io_pkg::WR_TICK, z180_io_pkg::WR_HOLD: begin
                // Long write cycles stay parked here and yield no more ticks
                if (iorq && wr) begin
                    state_next = z180_io_pkg::WR_HOLD;
                end
            end
            default: state_next = z180_io_pkg::WR_IDLE;
        endcase
    end

    // The tick window is the single cycle spent in WR_TICK
    assign wr_tick = (state_reg == z180_io_pkg::WR_TICK);

endmodule

`default_nettype wire

// File: io_wr_capture.sv
`timescale 1ns/1ps
`default_nettype none

// Capture stage for I/O writes into the four-port block
// Produces one queue push per matching bus write cycle
module io_wr_capture (
    input  wire                                   phi,
    input  wire                                   reset,
    input  wire                                   iorq,
    input  wire                                   wr,
    input  wire  [z180_io_pkg::ADDR_W-1:0]        addr,
    input  wire  [z180_io_pkg::DATA_W-1:0]        data,
    input  wire                                   full,
    output logic                                  push,
    output logic [z180_io_pkg::PORT_SEL_W-1:0]    push_port,
    output logic [z180_io_pkg::DATA_W-1:0]        push_data,
    output logic                                  overflow
);

    logic                                 wr_tick;
    logic                                 match_q;
    logic [z180_io_pkg::PORT_SEL_W-1:0]   port_q;
    logic [z180_io_pkg::DATA_W-1:0]       data_q;
    logic                                 accept;

    // **************************************************
    // Bus cycle detection
    // **************************************************

    iorq_wr_fsm iorq_wr_fsm_inst (
        .phi     (phi),
        .reset   (reset),
        .iorq    (iorq),
        .wr      (wr),
        .wr_tick (wr_tick)
    );

    // **************************************************
    // Address decode and payload sampling
    // **************************************************

    // The bus is sampled at the same edge the FSM sees iorq and wr
    // During the tick cycle these registers hold the values from the first edge
    always_ff @(posedge phi) begin
        match_q <= (addr[z180_io_pkg::ADDR_W-1:z180_io_pkg::PORT_SEL_W] ==
                    z180_io_pkg::PORT_BASE[z180_io_pkg::ADDR_W-1:z180_io_pkg::PORT_SEL_W]);
        port_q  <= addr[z180_io_pkg::PORT_SEL_W-1:0];
        data_q  <= data;
    end

    // A write belongs to this block when the tick is open and the upper bits match
    assign accept = wr_tick && match_q;

    // **************************************************
    // Queue push and overflow
    // **************************************************

    // The queue takes the entry at the edge that closes the tick cycle
    assign push      = accept && !full;
    assign push_port = port_q;
    assign push_data = data_q;

    // Sticky flag for a write lost to a full queue
    always_ff @(posedge phi) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (accept && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: io_wr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Synchronous circular queue of captured port writes
// Each entry holds a port index and the data byte written to it
module io_wr_fifo (
    input  wire                                   phi,
    input  wire                                   reset,
    input  wire                                   push,
    input  wire  [z180_io_pkg::PORT_SEL_W-1:0]    push_port,
    input  wire  [z180_io_pkg::DATA_W-1:0]        push_data,
    input  wire                                   pop,
    output logic                                  full,
    output logic                                  empty,
    output logic [z180_io_pkg::PORT_SEL_W-1:0]    head_port,
    output logic [z180_io_pkg::DATA_W-1:0]        head_data
);

    // **************************************************
    // Storage and pointers
    // **************************************************

    logic [z180_io_pkg::PORT_SEL_W-1:0] port_mem [z180_io_pkg::FIFO_DEPTH];
    logic [z180_io_pkg::DATA_W-1:0]     data_mem [z180_io_pkg::FIFO_DEPTH];

    logic [z180_io_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [z180_io_pkg::FIFO_PTR_W-1:0] rd_ptr;

    // One extra bit so a completely full queue can be told apart from empty
    logic [z180_io_pkg::FIFO_PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    // Pushes into a full queue and pops from an empty one are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // **************************************************
    // Control state
    // **************************************************

    always_ff @(posedge phi) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own because the depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // A push and a pop in the same edge leave the occupancy unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage is written at the tail
    always_ff @(posedge phi) begin
        if (do_push) begin
            port_mem[wr_ptr] <= push_port;
            data_mem[wr_ptr] <= push_data;
        end
    end

    // **************************************************
    // Status and head entry
    // **************************************************

    assign full  = (count == (z180_io_pkg::FIFO_PTR_W+1)'(z180_io_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // The oldest entry is always visible and only meaningful while empty is low
    assign head_port = port_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

endmodule

`default_nettype wire

// File: io_port_drain.sv
`timescale 1ns/1ps
`default_nettype none

// Drain stage that hands queued writes to the downstream agent
// Every entry goes out through one full four-phase req/ack exchange
module io_port_drain (
    input  wire                                   phi,
    input  wire                                   reset,
    input  wire                                   empty,
    input  wire  [z180_io_pkg::PORT_SEL_W-1:0]    head_port,
    input  wire  [z180_io_pkg::DATA_W-1:0]        head_data,
    output logic                                  pop,
    output logic                                  out_req,
    input  wire                                   out_ack,
    output logic [z180_io_pkg::PORT_SEL_W-1:0]    out_port,
    output logic [z180_io_pkg::DATA_W-1:0]        out_data
);

    z180_io_pkg::drain_state_t state_reg;
    z180_io_pkg::drain_state_t state_next;

    // **************************************************
    // Handshake FSM
    // **************************************************

    always_ff @(posedge phi) begin
        if (reset) begin
            state_reg <= z180_io_pkg::DR_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            z180_io_pkg::DR_IDLE: begin
                if (!empty) begin
                    state_next = z180_io_pkg::DR_LOAD;
                end
            end
            // Output registers were loaded on entry so req can go up now
            z180_io_pkg::DR_LOAD: state_next = z180_io_pkg::DR_REQ;
            z180_io_pkg::DR_REQ: begin
                if (out_ack) begin
                    state_next = z180_io_pkg::DR_RELEASE;
                end
            end
            // The agent must drop ack before the next entry is offered
            z180_io_pkg::DR_RELEASE: begin
                if (!out_ack) begin
                    state_next = z180_io_pkg::DR_IDLE;
                end
            end
            default: state_next = z180_io_pkg::DR_IDLE;
        endcase
    end

    // The head leaves the queue at the edge that moves the FSM into DR_LOAD
    assign pop = (state_reg == z180_io_pkg::DR_IDLE) && !empty;

    // **************************************************
    // Downstream outputs
    // **************************************************

    // Request goes high leaving DR_LOAD and low once ack is seen
    always_ff @(posedge phi) begin
        if (reset) begin
            out_req <= 1'b0;
        end else if (state_reg == z180_io_pkg::DR_LOAD) begin
            out_req <= 1'b1;
        end else if (state_reg == z180_io_pkg::DR_REQ && out_ack) begin
            out_req <= 1'b0;
        end
    end

    // Port and data stay stable from one edge before req rises until the next pop
    always_ff @(posedge phi) begin
        if (pop) begin
            out_port <= head_port;
            out_data <= head_data;
        end
    end

endmodule

`default_nettype wire

// File: z180_io_top.sv
`timescale 1ns/1ps
`default_nettype none

// Write side of the Z8S180 I/O port block
// Bus writes are captured, queued and then drained to the downstream agent
module z180_io_top (
    input  wire                                   phi,
    input  wire                                   reset,
    input  wire                                   iorq,
    input  wire                                   wr,
    input  wire  [z180_io_pkg::ADDR_W-1:0]        addr,
    input  wire  [z180_io_pkg::DATA_W-1:0]        data,
    output logic                                  out_req,
    input  wire                                   out_ack,
    output logic [z180_io_pkg::PORT_SEL_W-1:0]    out_port,
    output logic [z180_io_pkg::DATA_W-1:0]        out_data,
    output logic                                  overflow
);

    // Capture to queue
    logic                                 push;
    logic [z180_io_pkg::PORT_SEL_W-1:0]   push_port;
    logic [z180_io_pkg::DATA_W-1:0]       push_data;
    logic                                 full;

    // Queue to drain
    logic                                 pop;
    logic                                 empty;
    logic [z180_io_pkg::PORT_SEL_W-1:0]   head_port;
    logic [z180_io_pkg::DATA_W-1:0]       head_data;

    io_wr_capture io_wr_capture_inst (
        .phi       (phi),
        .reset     (reset),
        .iorq      (iorq),
        .wr        (wr),
        .addr      (addr),
        .data      (data),
        .full      (full),
        .push      (push),
        .push_port (push_port),
        .push_data (push_data),
        .overflow  (overflow)
    );

    io_wr_fifo io_wr_fifo_inst (
        .phi       (phi),
        .reset     (reset),
        .push      (push),
        .push_port (push_port),
        .push_data (push_data),
        .pop       (pop),
        .full      (full),
        .empty     (empty),
        .head_port (head_port),
        .head_data (head_data)
    );

    // Under back-pressure this stage holds one more entry beyond the queue
    io_port_drain io_port_drain_inst (
        .phi       (phi),
        .reset     (reset),
        .empty     (empty),
        .head_port (head_port),
        .head_data (head_data),
        .pop       (pop),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_port  (out_port),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: tb_z180_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_z180_io;

    logic                                 phi;
    logic                                 reset;
    logic                                 iorq;
    logic                                 wr;
    logic [z180_io_pkg::ADDR_W-1:0]       addr;
    logic [z180_io_pkg::DATA_W-1:0]       data;
    logic                                 out_req;
    logic                                 out_ack;
    logic [z180_io_pkg::PORT_SEL_W-1:0]   out_port;
    logic [z180_io_pkg::DATA_W-1:0]       out_data;
    logic                                 overflow;

    // Expected entries hold the port index above the data byte
    logic [z180_io_pkg::PORT_SEL_W+z180_io_pkg::DATA_W-1:0] exp_q[$];
    logic [z180_io_pkg::PORT_SEL_W+z180_io_pkg::DATA_W-1:0] head_entry;

    int   backlog;
    int   ack_delay;
    bit   stalled;
    bit   exp_overflow;
    bit   req_prev;

    z180_io_top z180_io_top_inst (
        .phi      (phi),
        .reset    (reset),
        .iorq     (iorq),
        .wr       (wr),
        .addr     (addr),
        .data     (data),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_port (out_port),
        .out_data (out_data),
        .overflow (overflow)
    );

    always #20 phi = ~phi;

    // **************************************************
    // Reporting
    // **************************************************

    task automatic show_states();
        z180_io_pkg::wr_state_t    wr_now;
        z180_io_pkg::drain_state_t dr_now;
        wr_now = z180_io_top_inst.io_wr_capture_inst.iorq_wr_fsm_inst.state_reg;
        dr_now = z180_io_top_inst.io_port_drain_inst.state_reg;
        $display("  write FSM in %s, drain FSM in %s", wr_now.name(), dr_now.name());
    endtask

    task automatic fail_run(input string msg);
        $display("%s at time %0t", msg, $time);
        show_states();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: time %0t signal %s expected %0h actual %0h",
                     $time, name, expected, actual);
            show_states();
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // **************************************************
    // Reference model
    // **************************************************

    // The block covers four consecutive addresses starting at the base
    function automatic bit accepts_write(input logic [z180_io_pkg::ADDR_W-1:0] a);
        return (a >= z180_io_pkg::PORT_BASE) &&
               (a < z180_io_pkg::PORT_BASE + (1 << z180_io_pkg::PORT_SEL_W));
    endfunction

    // With the agent stalled the queue plus the drain register hold FIFO_DEPTH plus one
    task automatic model_write(input logic [7:0] a, input logic [7:0] d);
        if (accepts_write(a)) begin
            if (stalled && backlog >= z180_io_pkg::FIFO_DEPTH + 1) begin
                exp_overflow = 1'b1;
            end else begin
                exp_q.push_back({(z180_io_pkg::PORT_SEL_W)'(a - z180_io_pkg::PORT_BASE), d});
                backlog = backlog + 1;
            end
        end
    endtask

    // **************************************************
    // Bus and downstream agent
    // **************************************************

    // The bus cycle lasts the given number of phi cycles and then idles for one
    task automatic bus_cycle(input bit is_write, input logic [7:0] a, input logic [7:0] d,
                             input int cycles);
        if (is_write) begin
            model_write(a, d);
        end
        iorq = 1'b1;
        wr   = is_write;
        addr = a;
        data = d;
        repeat (cycles) @(negedge phi);
        iorq = 1'b0;
        wr   = 1'b0;
        @(negedge phi);
    endtask

    // Ack follows req after 0 to 3 cycles unless the agent is stalled
    always @(negedge phi) begin
        if (reset) begin
            out_ack   = 1'b0;
            ack_delay = 0;
        end else if (!out_ack) begin
            if (out_req && !stalled) begin
                if (ack_delay == 0) begin
                    out_ack = 1'b1;
                end else begin
                    ack_delay = ack_delay - 1;
                end
            end else begin
                ack_delay = $urandom_range(3, 0);
            end
        end else if (!out_req) begin
            // Req has dropped so the exchange for this entry is complete
            out_ack = 1'b0;
            backlog = backlog - 1;
        end
    end

    // Each rising req is matched against the oldest expected entry
    always @(negedge phi) begin
        if (reset) begin
            req_prev = 1'b0;
        end else begin
            if (out_req && !req_prev) begin
                if (exp_q.size() == 0) begin
                    fail_run("an output entry appeared while none was expected");
                end else begin
                    head_entry = exp_q.pop_front();
                    check_value("out_port", 32'(head_entry[9:8]), 32'(out_port));
                    check_value("out_data", 32'(head_entry[7:0]), 32'(out_data));
                end
            end
            req_prev = out_req;
        end
    end

    task automatic apply_reset();
        reset = 1'b1;
        exp_q.delete();
        backlog      = 0;
        exp_overflow = 1'b0;
        stalled      = 1'b0;
        repeat (3) @(negedge phi);
        reset = 1'b0;
    endtask

    // Waits until every expected entry has gone through its handshake, then stays quiet
    task automatic wait_idle();
        int cycles = 0;
        while (exp_q.size() != 0 || backlog != 0 || out_ack) begin
            @(negedge phi);
            cycles = cycles + 1;
            if (cycles > 300) begin
                fail_run("timed out waiting for the expected entries to drain");
            end
        end
        repeat (8) @(negedge phi);
    endtask

    // Waits until the drain stage offers an entry downstream
    task automatic wait_for_req();
        int cycles = 0;
        while (!out_req) begin
            @(negedge phi);
            cycles = cycles + 1;
            if (cycles > 20) begin
                fail_run("timed out waiting for out_req to rise");
            end
        end
    endtask

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin
        logic [7:0] a;
        logic [7:0] d;
        phi       = 1'b0;
        reset     = 1'b1;
        iorq      = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        data      = '0;
        out_ack   = 1'b0;
        void'($urandom(32'hcd19_bbd9));
        apply_reset();

        // Random writes to the four ports, in bursts the queue can absorb
        for (int i = 0; i < 16; i++) begin
            a = z180_io_pkg::PORT_BASE | 8'($urandom_range(3, 0));
            d = 8'($urandom);
            bus_cycle(1'b1, a, d, 3);
            if (i % 4 == 3) begin
                wait_idle();
            end
        end

        // Writes outside the block are ignored
        for (int i = 0; i < 8; i++) begin
            a = 8'($urandom);
            if (accepts_write(a)) begin
                a = a ^ 8'h80;
            end
            bus_cycle(1'b1, a, 8'($urandom), 3);
        end
        // Reads hit the block address but carry no write
        bus_cycle(1'b0, z180_io_pkg::PORT_BASE + 8'd1, 8'h5a, 3);
        bus_cycle(1'b0, z180_io_pkg::PORT_BASE + 8'd3, 8'ha5, 3);
        // A long write cycle still yields a single entry
        bus_cycle(1'b1, z180_io_pkg::PORT_BASE + 8'd2, 8'h3c, 12);
        wait_idle();

        // Six writes against a stalled agent overflow by one
        stalled = 1'b1;
        for (int i = 0; i < 6; i++) begin
            bus_cycle(1'b1, z180_io_pkg::PORT_BASE + 8'(i % 4), 8'(8'h10 + i), 3);
        end
        check_value("overflow", 32'(exp_overflow), 32'(overflow));
        stalled = 1'b0;
        wait_idle();

        // Reset arrives while an entry is still offered downstream
        stalled = 1'b1;
        bus_cycle(1'b1, z180_io_pkg::PORT_BASE + 8'd1, 8'h96, 3);
        wait_for_req();
        // The compare process takes the offered entry before the model is cleared
        @(negedge phi);

        // A fresh reset clears the request and the sticky flag and the block still works
        apply_reset();
        check_value("out_req", 32'd0, 32'(out_req));
        check_value("overflow", 32'd0, 32'(overflow));
        bus_cycle(1'b1, z180_io_pkg::PORT_BASE + 8'd3, 8'hc7, 3);
        wait_idle();
        check_value("overflow", 32'd0, 32'(overflow));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
z180_io_pkg.sv
iorq_wr_fsm.sv
io_wr_capture.sv
io_wr_fifo.sv
io_port_drain.sv
z180_io_top.sv
tb_z180_io.sv

// File: Makefile
# Verilator build and run for the Z8S180 I/O write block

VERILATOR ?= verilator
TOP       ?= tb_z180_io
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
